/* tb.f */
design/game_pkg.sv
design/video_if.sv
design/frame_source.sv
design/enemy_sprite.sv
design/enemy_chain.sv
design/game_ctrl.sv
design/game_top.sv
verification/game_tb.sv

/* verification/game_tb.sv */
`timescale 1ns/10ps

module game_tb;
  import game_pkg::*;

  // small frame so a full run stays short
  localparam int H_ACTIVE      = 96;
  localparam int H_SYNC_START  = 100;
  localparam int H_SYNC_END    = 110;
  localparam int H_TOTAL       = 120;
  localparam int V_ACTIVE      = 100;
  localparam int V_SYNC_START  = 102;
  localparam int V_SYNC_END    = 104;
  localparam int V_TOTAL       = 110;
  localparam int ENEMY_SPACING = 24;
  localparam int NUM_FRAMES    = 60;
  localparam int FRAME_CYCLES  = H_TOTAL * V_TOTAL;

  logic   pclk;
  logic   rst_n;
  coord_t xpos_missile;
  coord_t ypos_missile;
  logic   on_missile;
  coord_t vcount_o;
  coord_t hcount_o;
  logic   vsync_o;
  logic   vblnk_o;
  logic   hsync_o;
  logic   hblnk_o;
  rgb_t   rgb_o;
  level_t level_o;

  // reference model state
  logic [2:0] alive_m;
  int         level_m;
  int         prev_h;
  int         prev_v;
  logic       prev_vsync;
  logic       missile_drawn;
  int         kills;
  int         level_ups;

  game_top #(
    .H_ACTIVE      (H_ACTIVE),
    .H_SYNC_START  (H_SYNC_START),
    .H_SYNC_END    (H_SYNC_END),
    .H_TOTAL       (H_TOTAL),
    .V_ACTIVE      (V_ACTIVE),
    .V_SYNC_START  (V_SYNC_START),
    .V_SYNC_END    (V_SYNC_END),
    .V_TOTAL       (V_TOTAL),
    .ENEMY_SPACING (ENEMY_SPACING)
  ) UUT (
    .pclk           (pclk),
    .rst_n_i        (rst_n),
    .xpos_missile_i (xpos_missile),
    .ypos_missile_i (ypos_missile),
    .on_missile_i   (on_missile),
    .vcount_o       (vcount_o),
    .vsync_o        (vsync_o),
    .vblnk_o        (vblnk_o),
    .hcount_o       (hcount_o),
    .hsync_o        (hsync_o),
    .hblnk_o        (hblnk_o),
    .rgb_o          (rgb_o),
    .level_o        (level_o)
  );

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  task automatic check_value(input logic [31:0] expected, input logic [31:0] actual,
                             input string what);
    if (expected !== actual) begin
      $display("ERROR at %0t ns: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t ns while waiting for %s", $time, what);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped on timeout");
  endtask

  // box of enemy n at a level, both edges included
  function automatic bit in_enemy_box(input int x, input int y, input int n, input int lvl);
    int left;
    int top;
    left = ENEMY_SPACING * n;
    top  = ENEMY_Y0 + LEVEL_STEP * lvl;
    return (x >= left) && (x <= left + ENEMY_SIZE - 1) &&
           (y >= top) && (y <= top + ENEMY_SIZE - 1);
  endfunction

  function automatic int expected_rgb(input int x, input int y);
    int n;
    if (x >= H_ACTIVE || y >= V_ACTIVE)
      return 0;
    for (n = 1; n <= 3; n++) begin
      if (alive_m[n-1] && in_enemy_box(x, y, n, level_m))
        return ENEMY_COLOR;
    end
    return BG_COLOR;
  endfunction

  // half the draws aim into a box at the current level
  task automatic draw_missile();
    int n;
    if ($urandom_range(1, 0) == 1) begin
      n = $urandom_range(3, 1);
      xpos_missile = coord_t'(ENEMY_SPACING * n + $urandom_range(ENEMY_SIZE - 1, 0));
      ypos_missile = coord_t'(ENEMY_Y0 + LEVEL_STEP * level_m +
                              $urandom_range(ENEMY_SIZE - 1, 0));
    end else begin
      xpos_missile = coord_t'($urandom_range(H_TOTAL - 1, 0));
      ypos_missile = coord_t'($urandom_range(V_TOTAL - 1, 0));
    end
    on_missile = ($urandom_range(3, 0) != 0);
  endtask

  // checks one output pixel, called 1 ns after the edge
  task automatic check_outputs(output bit vsync_rise);
    int h;
    int v;
    int exp_h;
    int exp_v;
    h = int'(hcount_o);
    v = int'(vcount_o);
    exp_h = (prev_h == H_TOTAL - 1) ? 0 : prev_h + 1;
    exp_v = prev_v;
    if (prev_h == H_TOTAL - 1)
      exp_v = (prev_v == V_TOTAL - 1) ? 0 : prev_v + 1;
    check_value(exp_h, h, "hcount step");
    check_value(exp_v, v, "vcount step");
    check_value(h >= H_SYNC_START && h < H_SYNC_END, hsync_o, "hsync");
    check_value(v >= V_SYNC_START && v < V_SYNC_END, vsync_o, "vsync");
    check_value(h >= H_ACTIVE, hblnk_o, "hblnk");
    check_value(v >= V_ACTIVE, vblnk_o, "vblnk");
    check_value(expected_rgb(h, v), rgb_o, $sformatf("rgb at x %0d y %0d", h, v));
    vsync_rise = vsync_o && !prev_vsync;
    prev_h     = h;
    prev_v     = v;
    prev_vsync = vsync_o;
    if (v == 0 && !missile_drawn) begin
      draw_missile();
      missile_drawn = 1'b1;
    end
  endtask

  // model step at the output vsync edge, missile as held now
  task automatic apply_frame_end();
    int n;
    if (alive_m == 3'b000) begin
      alive_m = 3'b111;   // respawn, hits ignored
      if (level_m < 15)
        level_m++;
      level_ups++;
    end else if (on_missile) begin
      for (n = 1; n <= 3; n++) begin
        if (alive_m[n-1] && in_enemy_box(xpos_missile, ypos_missile, n, level_m)) begin
          alive_m[n-1] = 1'b0;
          kills++;
        end
      end
    end
    check_value(level_m, level_o, "level after frame end");
    missile_drawn = 1'b0;
  endtask

  initial begin
    int  seed_init;
    int  frame;
    int  cycles;
    bit  rise;
    seed_init    = $urandom(32'h9f02_f170);
    rst_n        = 1'b0;
    xpos_missile = '0;
    ypos_missile = '0;
    on_missile   = 1'b0;
    alive_m       = 3'b111;
    level_m       = 0;
    prev_h        = 0;
    prev_v        = 0;
    prev_vsync    = 1'b0;
    missile_drawn = 1'b0;
    kills         = 0;
    level_ups     = 0;

    repeat (5) @(posedge pclk);
    #1;
    check_value(0, level_o, "level after reset");
    check_value(0, hsync_o | vsync_o, "syncs after reset");
    check_value(0, hblnk_o | vblnk_o, "blanks after reset");
    rst_n = 1'b1;

    // pipeline holds reset values until the first real pixel 1 arrives
    cycles = 0;
    do begin
      @(posedge pclk);
      #1;
      cycles++;
      if (cycles > 50)
        report_timeout("the first output pixel after reset");
    end while (hcount_o != 1);
    check_outputs(rise);

    for (frame = 0; frame < NUM_FRAMES; frame++) begin
      cycles = 0;
      rise   = 1'b0;
      while (!rise) begin
        if (cycles > FRAME_CYCLES + 10)
          report_timeout($sformatf("vsync of frame %0d", frame));
        @(posedge pclk);
        #1;
        check_outputs(rise);
        cycles++;
      end
      apply_frame_end();
    end

    $display("frames %0d, kills %0d, level ups %0d, final level %0d",
             NUM_FRAMES, kills, level_ups, level_m);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* design/game_top.sv */
`timescale 1ns/10ps

module game_top #(
  parameter int H_ACTIVE      = 640,
  parameter int H_SYNC_START  = 656,
  parameter int H_SYNC_END    = 752,
  parameter int H_TOTAL       = 800,
  parameter int V_ACTIVE      = 480,
  parameter int V_SYNC_START  = 490,
  parameter int V_SYNC_END    = 492,
  parameter int V_TOTAL       = 525,
  parameter int ENEMY_SPACING = 160
) (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  game_pkg::coord_t xpos_missile_i,
  input  game_pkg::coord_t ypos_missile_i,
  input  logic             on_missile_i,
  output game_pkg::coord_t vcount_o,
  output logic             vsync_o,
  output logic             vblnk_o,
  output game_pkg::coord_t hcount_o,
  output logic             hsync_o,
  output logic             hblnk_o,
  output game_pkg::rgb_t   rgb_o,
  output game_pkg::level_t level_o
);

  video_if src_vid ();  // background stream
  video_if out_vid ();  // after all three enemies

  logic       frame_end;
  logic       respawn;
  logic [2:0] alive;

  frame_source #(
    .H_ACTIVE     (H_ACTIVE),
    .H_SYNC_START (H_SYNC_START),
    .H_SYNC_END   (H_SYNC_END),
    .H_TOTAL      (H_TOTAL),
    .V_ACTIVE     (V_ACTIVE),
    .V_SYNC_START (V_SYNC_START),
    .V_SYNC_END   (V_SYNC_END),
    .V_TOTAL      (V_TOTAL)
  ) u_frame_source (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .vid_o       (src_vid),
    .frame_end_o (frame_end)
  );

  game_ctrl u_game_ctrl (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .frame_end_i (frame_end),
    .alive_i     (alive),
    .level_o     (level_o),
    .respawn_o   (respawn)
  );

  enemy_chain #(.ENEMY_SPACING(ENEMY_SPACING)) u_enemy_chain (
    .pclk           (pclk),
    .rst_n_i        (rst_n_i),
    .vid_i          (src_vid),
    .vid_o          (out_vid),
    .xpos_missile_i (xpos_missile_i),
    .ypos_missile_i (ypos_missile_i),
    .on_missile_i   (on_missile_i),
    .level_i        (level_o),
    .frame_end_i    (frame_end),
    .respawn_i      (respawn),
    .alive_o        (alive)
  );

  // flatten the output stream to plain ports
  assign vcount_o = out_vid.vcount;
  assign vsync_o  = out_vid.vsync;
  assign vblnk_o  = out_vid.vblnk;
  assign hcount_o = out_vid.hcount;
  assign hsync_o  = out_vid.hsync;
  assign hblnk_o  = out_vid.hblnk;
  assign rgb_o    = out_vid.rgb;

endmodule

/* design/game_ctrl.sv */
`timescale 1ns/10ps

module game_ctrl (
  input  logic             pclk,
  input  logic             rst_n_i,
  input  logic             frame_end_i,
  input  logic [2:0]       alive_i,
  output game_pkg::level_t level_o,
  output logic             respawn_o
);
  import game_pkg::*;

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        all_dead;

  assign all_dead = (alive_i == 3'b000);

  // respawn lines up with the frame end pulse itself
  assign respawn_o = frame_end_i && (state == CLEARED);

  always_comb begin
    state_nxt = state;
    case (state)
      PLAY: begin
        if (all_dead)
          state_nxt = CLEARED;
      end
      CLEARED: begin
        if (frame_end_i)
          state_nxt = PLAY;  // enemies come back this frame end
      end
      default: state_nxt = PLAY;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i)
      state <= PLAY;
    else
      state <= state_nxt;
  end

  // level goes up once per cleared wave
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      level_o <= '0;
    end else if (respawn_o && !(&level_o)) begin
      level_o <= level_o + 1'b1;  // holds at 15
    end
  end

endmodule

/* design/enemy_chain.sv */
`timescale 1ns/10ps

module enemy_chain #(
  parameter int ENEMY_SPACING = 160
) (
  input  logic             pclk,
  input  logic             rst_n_i,
  video_if.sink            vid_i,
  video_if.source          vid_o,
  input  game_pkg::coord_t xpos_missile_i,
  input  game_pkg::coord_t ypos_missile_i,
  input  logic             on_missile_i,
  input  game_pkg::level_t level_i,
  input  logic             frame_end_i,
  input  logic             respawn_i,
  output logic [2:0]       alive_o
);

  video_if link_1 ();  // enemy_1 to enemy_2
  video_if link_2 ();  // enemy_2 to enemy_3

  enemy_sprite #(.N(1), .ENEMY_SPACING(ENEMY_SPACING)) enemy_1 (
    .pclk           (pclk),
    .rst_n_i        (rst_n_i),
    .vid_i          (vid_i),
    .vid_o          (link_1),
    .xpos_missile_i (xpos_missile_i),
    .ypos_missile_i (ypos_missile_i),
    .on_missile_i   (on_missile_i),
    .level_i        (level_i),
    .frame_end_i    (frame_end_i),
    .respawn_i      (respawn_i),
    .alive_o        (alive_o[0])
  );

  enemy_sprite #(.N(2), .ENEMY_SPACING(ENEMY_SPACING)) enemy_2 (
    .pclk           (pclk),
    .rst_n_i        (rst_n_i),
    .vid_i          (link_1),
    .vid_o          (link_2),
    .xpos_missile_i (xpos_missile_i),
    .ypos_missile_i (ypos_missile_i),
    .on_missile_i   (on_missile_i),
    .level_i        (level_i),
    .frame_end_i    (frame_end_i),
    .respawn_i      (respawn_i),
    .alive_o        (alive_o[1])
  );

  // last stage feeds the chain output
  enemy_sprite #(.N(3), .ENEMY_SPACING(ENEMY_SPACING)) enemy_3 (
    .pclk           (pclk),
    .rst_n_i        (rst_n_i),
    .vid_i          (link_2),
    .vid_o          (vid_o),
    .xpos_missile_i (xpos_missile_i),
    .ypos_missile_i (ypos_missile_i),
    .on_missile_i   (on_missile_i),
    .level_i        (level_i),
    .frame_end_i    (frame_end_i),
    .respawn_i      (respawn_i),
    .alive_o        (alive_o[2])
  );

endmodule

/* design/enemy_sprite.sv */
`timescale 1ns/10ps

module enemy_sprite #(
  parameter int N             = 1,    // enemy index
  parameter int ENEMY_SPACING = 160
) (
  input  logic             pclk,
  input  logic             rst_n_i,
  video_if.sink            vid_i,
  video_if.source          vid_o,
  input  game_pkg::coord_t xpos_missile_i,
  input  game_pkg::coord_t ypos_missile_i,
  input  logic             on_missile_i,
  input  game_pkg::level_t level_i,
  input  logic             frame_end_i,
  input  logic             respawn_i,
  output logic             alive_o
);
  import game_pkg::*;

  // horizontal edges are fixed per stage
  localparam coord_t X_LEFT  = coord_t'(N * ENEMY_SPACING);
  localparam coord_t X_RIGHT = coord_t'(N * ENEMY_SPACING + ENEMY_SIZE - 1);

  coord_t y_top;
  logic   hit;
  logic   draw;

  // true when the point lies inside the box, edges included
  function automatic logic in_box(input coord_t x, input coord_t y, input coord_t top);
    logic in_x;
    logic in_y;
    in_x = (x >= X_LEFT) && (x <= X_RIGHT);
    in_y = (y >= top) && (y <= top + coord_t'(ENEMY_SIZE - 1));
    return in_x && in_y;
  endfunction

  assign y_top = coord_t'(ENEMY_Y0 + LEVEL_STEP * level_i);  // moves down with level

  assign hit = on_missile_i && in_box(xpos_missile_i, ypos_missile_i, y_top);

  // alive flag only changes at frame end, inside vertical blank
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      alive_o <= 1'b1;
    end else if (frame_end_i) begin
      if (respawn_i)
        alive_o <= 1'b1;   // hits ignored on a respawn pulse
      else if (hit)
        alive_o <= 1'b0;
    end
  end

  assign draw = alive_o && !vid_i.hblnk && !vid_i.vblnk &&
                in_box(vid_i.hcount, vid_i.vcount, y_top);

  // one cycle of delay on every stream signal
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      vid_o.hcount <= '0;
      vid_o.vcount <= '0;
      vid_o.hsync  <= 1'b0;
      vid_o.vsync  <= 1'b0;
      vid_o.hblnk  <= 1'b0;
      vid_o.vblnk  <= 1'b0;
      vid_o.rgb    <= '0;
    end else begin
      vid_o.hcount <= vid_i.hcount;
      vid_o.vcount <= vid_i.vcount;
      vid_o.hsync  <= vid_i.hsync;
      vid_o.vsync  <= vid_i.vsync;
      vid_o.hblnk  <= vid_i.hblnk;
      vid_o.vblnk  <= vid_i.vblnk;
      vid_o.rgb    <= draw ? ENEMY_COLOR : vid_i.rgb;  // paint over background
    end
  end

endmodule

/* design/frame_source.sv */
`timescale 1ns/10ps

module frame_source #(
  parameter int H_ACTIVE     = 640,
  parameter int H_SYNC_START = 656,
  parameter int H_SYNC_END   = 752,
  parameter int H_TOTAL      = 800,
  parameter int V_ACTIVE     = 480,
  parameter int V_SYNC_START = 490,
  parameter int V_SYNC_END   = 492,
  parameter int V_TOTAL      = 525
) (
  input  logic    pclk,
  input  logic    rst_n_i,
  video_if.source vid_o,
  output logic    frame_end_o
);
  import game_pkg::*;

  coord_t hcnt;
  coord_t vcnt;
  logic   line_end;
  logic   frame_wrap;
  logic   hblnk_c;
  logic   vblnk_c;
  logic   hsync_c;
  logic   vsync_c;
  logic   frame_end_c;

  assign line_end   = (hcnt == coord_t'(H_TOTAL - 1));
  assign frame_wrap = line_end && (vcnt == coord_t'(V_TOTAL - 1));

  // pixel and line counters
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      hcnt <= '0;
      vcnt <= '0;
    end else begin
      hcnt <= line_end ? '0 : hcnt + 1'b1;
      if (frame_wrap)
        vcnt <= '0;
      else if (line_end)
        vcnt <= vcnt + 1'b1;
    end
  end

  // compare rules on the live counters
  assign hblnk_c = (hcnt >= coord_t'(H_ACTIVE));
  assign vblnk_c = (vcnt >= coord_t'(V_ACTIVE));
  assign hsync_c = (hcnt >= coord_t'(H_SYNC_START)) && (hcnt < coord_t'(H_SYNC_END));
  assign vsync_c = (vcnt >= coord_t'(V_SYNC_START)) && (vcnt < coord_t'(V_SYNC_END));

  // first pixel of the first vsync line
  assign frame_end_c = (vcnt == coord_t'(V_SYNC_START)) && (hcnt == '0);

  // registered stream, one cycle behind the counters
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      vid_o.hcount <= '0;
      vid_o.vcount <= '0;
      vid_o.hsync  <= 1'b0;
      vid_o.vsync  <= 1'b0;
      vid_o.hblnk  <= 1'b0;
      vid_o.vblnk  <= 1'b0;
      vid_o.rgb    <= '0;
      frame_end_o  <= 1'b0;
    end else begin
      vid_o.hcount <= hcnt;
      vid_o.vcount <= vcnt;
      vid_o.hsync  <= hsync_c;
      vid_o.vsync  <= vsync_c;
      vid_o.hblnk  <= hblnk_c;
      vid_o.vblnk  <= vblnk_c;
      vid_o.rgb    <= (hblnk_c || vblnk_c) ? '0 : BG_COLOR;  // black in blanking
      frame_end_o  <= frame_end_c;
    end
  end

endmodule

/* design/video_if.sv */
`timescale 1ns/10ps

interface video_if;
  import game_pkg::*;

  coord_t vcount;
  logic   vsync;
  logic   vblnk;
  coord_t hcount;
  logic   hsync;
  logic   hblnk;
  rgb_t   rgb;

  // driver side of the stream
  modport source (
    output vcount, vsync, vblnk,
    output hcount, hsync, hblnk,
    output rgb
  );

  // receiver side of the stream
  modport sink (
    input vcount, vsync, vblnk,
    input hcount, hsync, hblnk,
    input rgb
  );

endinterface

/* design/game_pkg.sv */
package game_pkg;

  // widths with a meaning
  typedef logic [10:0] coord_t;   // pixel or line position
  typedef logic [11:0] rgb_t;     // 4 bits per channel, r g b
  typedef logic [3:0]  level_t;   // game level, saturates at 15

  // colours
  localparam rgb_t BG_COLOR    = 12'h00F;  // blue sky
  localparam rgb_t ENEMY_COLOR = 12'hF00;  // red box

  // enemy geometry
  localparam int ENEMY_SIZE = 16;  // square side in pixels
  localparam int ENEMY_Y0   = 8;   // top edge at level 0
  localparam int LEVEL_STEP = 4;   // lines lower per level

  // game controller states
  typedef enum logic {
    PLAY,     // at least one enemy still alive
    CLEARED   // all dead, wait for frame end to respawn
  } ctrl_state_t;

endpackage
